/* Makefile */
SIM  := obj_dir/Vtb_core_slice
SRCS := $(filter-out +%,$(shell cat build.f))

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS) test/tb_rv_model.svh
	verilator --binary --timing --assert --top-module tb_core_slice -f build.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+test
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/id_ex_regs.sv
hw/rv_alu_stage.sv
hw/rv_ctrl_regs.sv
hw/rv_core_slice.sv
test/tb_core_slice.sv

/* hw/id_ex_regs.sv */
module id_ex_regs
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  id_ex_t id_ex_i,
    output id_ex_t id_ex_o
);

    // whole bundle moves every cycle and bubbles carry valid low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o    <= '0;
            id_ex_o.pc <= RESET_PC;                       // boot pc
        end else begin
            id_ex_o <= id_ex_i;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(id_ex_o.valid));

endmodule

/* hw/rv_alu_stage.sv */
module rv_alu_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  id_ex_t                id_ex_i,
    output logic                  fwd_wen_o,
    output logic [REG_ADDR_W-1:0] fwd_rd_o,
    output logic [XLEN-1:0]       fwd_data_o,
    output logic                  rf_wen_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output retire_t               retire_o,
    output logic                  retire_pulse_o
);

    logic [XLEN-1:0]    a, b, result;
    logic [SHAMT_W-1:0] shamt;

    assign a     = id_ex_i.src1;
    assign b     = id_ex_i.src2;
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign rf_wen_o   = id_ex_i.valid && id_ex_i.wen && !id_ex_i.illegal && (id_ex_i.rd != '0);
    assign rf_waddr_o = id_ex_i.rd;
    assign rf_wdata_o = result;

    assign fwd_wen_o  = rf_wen_o;                         // same value the regfile takes
    assign fwd_rd_o   = id_ex_i.rd;
    assign fwd_data_o = result;

    assign retire_pulse_o = id_ex_i.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_o <= '0;
        end else begin
            retire_o.valid   <= id_ex_i.valid;
            retire_o.pc      <= id_ex_i.pc;
            retire_o.rd      <= id_ex_i.rd;
            retire_o.wen     <= rf_wen_o;
            retire_o.data    <= rf_wen_o ? result : '0;   // zero when nothing written
            retire_o.ebreak  <= id_ex_i.ebreak;
            retire_o.illegal <= id_ex_i.illegal;
        end
    end

    // decoded bundle never asks for a write on an ebreak or an illegal encoding
    assert property (@(posedge clk) disable iff (!rst_n)
        id_ex_i.valid && (id_ex_i.ebreak || id_ex_i.illegal) |-> !id_ex_i.wen);

endmodule

/* hw/rv_core_slice.sv */
module rv_core_slice
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid_i,
    input  logic [INST_W-1:0] inst_i,
    input  logic [XLEN-1:0]   pc_i,
    output logic              inst_ready_o,
    output retire_t           retire_o,
    input  apb_req_t          apb_i,
    output apb_rsp_t          apb_o
);

    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic                  fwd_wen;
    logic [REG_ADDR_W-1:0] fwd_rd;
    logic [XLEN-1:0]       fwd_data;
    logic                  rf_wen;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    id_ex_t                id_bundle, ex_bundle;
    logic                  halt_req, accept_en, retire_pulse;

    rv_decoder u_decoder (
        .clk, .rst_n,
        .inst_valid_i, .inst_i, .pc_i,
        .accept_en_i  (accept_en),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_wen_i    (fwd_wen),
        .fwd_rd_i     (fwd_rd),
        .fwd_data_i   (fwd_data),
        .id_ex_o      (id_bundle),
        .inst_ready_o,
        .halt_req_o   (halt_req)
    );

    rv_regfile u_regfile (
        .clk, .rst_n,
        .raddr1_i (rs1_addr), .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data), .rdata2_o (rs2_data),
        .wen_i    (rf_wen), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
    );

    id_ex_regs u_id_ex_regs (.clk, .rst_n, .id_ex_i (id_bundle), .id_ex_o (ex_bundle));

    rv_alu_stage u_alu_stage (
        .clk, .rst_n,
        .id_ex_i    (ex_bundle),
        .fwd_wen_o  (fwd_wen), .fwd_rd_o (fwd_rd), .fwd_data_o (fwd_data),
        .rf_wen_o   (rf_wen), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
        .retire_o,
        .retire_pulse_o (retire_pulse)
    );

    rv_ctrl_regs u_ctrl_regs (
        .clk, .rst_n,
        .apb_i, .apb_o,
        .halt_req_i     (halt_req),
        .halt_pc_i      (pc_i[APB_DW-1:0]),           // low half of the ebreak pc
        .retire_pulse_i (retire_pulse),
        .accept_en_o    (accept_en)
    );

endmodule

/* hw/rv_ctrl_regs.sv */
module rv_ctrl_regs
    import rv_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  apb_req_t          apb_i,
    output apb_rsp_t          apb_o,
    input  logic              halt_req_i,
    input  logic [APB_DW-1:0] halt_pc_i,
    input  logic              retire_pulse_i,
    output logic              accept_en_o
);

    logic              run, halted;
    logic [APB_DW-1:0] retired_cnt, halt_pc;
    logic [APB_DW-1:0] rdata;
    logic              access, wr_en, mapped, read_only;

    assign access = apb_i.psel && apb_i.penable;          // enable phase
    assign wr_en  = access && apb_i.pwrite;

    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (apb_i.paddr)
            CTRL_ADDR:    rdata = {{(APB_DW-1){1'b0}}, run};
            STATUS_ADDR:  rdata = {{(APB_DW-1){1'b0}}, halted};
            RETIRED_ADDR: begin
                rdata     = retired_cnt;
                read_only = 1'b1;
            end
            HALT_PC_ADDR: begin
                rdata     = halt_pc;
                read_only = 1'b1;
            end
            default:      mapped = 1'b0;
        endcase
    end

    assign apb_o.prdata  = rdata;
    assign apb_o.pready  = 1'b1;                          // no wait states
    assign apb_o.pslverr = access && (!mapped || (apb_i.pwrite && read_only));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run         <= 1'b0;
            halted      <= 1'b0;
            halt_pc     <= '0;
            retired_cnt <= '0;
        end else begin
            if (wr_en && (apb_i.paddr == CTRL_ADDR)) begin
                run <= apb_i.pwdata[0];
            end
            if (halt_req_i) begin
                halted  <= 1'b1;                          // set beats w1c
                halt_pc <= halt_pc_i;
            end else if (wr_en && (apb_i.paddr == STATUS_ADDR) && apb_i.pwdata[0]) begin
                halted <= 1'b0;
            end
            if (retire_pulse_i) begin
                retired_cnt <= retired_cnt + 1'b1;        // wraps
            end
        end
    end

    assign accept_en_o = run && !halted;

    // setup is always followed by an enable that completes at once
    assert property (@(posedge clk) disable iff (!rst_n)
        (apb_i.psel && !apb_i.penable) |=> (apb_i.psel && apb_i.penable && apb_o.pready));

endmodule

/* hw/rv_decoder.sv */
module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  accept_en_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  fwd_wen_i,
    input  logic [REG_ADDR_W-1:0] fwd_rd_i,
    input  logic [XLEN-1:0]       fwd_data_i,
    output id_ex_t                id_ex_o,
    output logic                  inst_ready_o,
    output logic                  halt_req_o
);

    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd, rs1, rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       imm_i, imm_u, imm;
    logic [XLEN-1:0]       rs1_val, rs2_val;
    logic                  fwd1, fwd2;
    logic                  accept, use_imm, wen, ebreak, illegal;
    alu_op_e               alu_op;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    assign inst_ready_o = accept_en_i;
    assign accept       = inst_valid_i && accept_en_i;

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        imm     = imm_i;
        wen     = 1'b0;
        ebreak  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:  alu_op = ALU_ADD;
                    {F7_ALT,  F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_SLL}:  alu_op = ALU_SLL;
                    {F7_BASE, F3_SLT}:  alu_op = ALU_SLT;
                    {F7_BASE, F3_SLTU}: alu_op = ALU_SLTU;
                    {F7_BASE, F3_XOR}:  alu_op = ALU_XOR;
                    {F7_BASE, F3_SR}:   alu_op = ALU_SRL;
                    {F7_ALT,  F3_SR}:   alu_op = ALU_SRA;
                    {F7_BASE, F3_OR}:   alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:  alu_op = ALU_AND;
                    default:            illegal = 1'b1;
                endcase
                wen = !illegal;
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    F3_SLL: begin
                        alu_op  = ALU_SLL;
                        illegal = (inst_i[31:26] != 6'b000000);
                    end
                    default: begin                        // srli / srai
                        alu_op  = inst_i[30] ? ALU_SRA : ALU_SRL;
                        illegal = ({inst_i[31], inst_i[29:26]} != 5'b00000);
                    end
                endcase
                wen = !illegal;
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
                wen     = 1'b1;
            end
            OPC_SYSTEM: begin
                ebreak  = (inst_i == EBREAK_INST);
                illegal = !ebreak;                        // no csr support
            end
            default: illegal = 1'b1;
        endcase
    end

    // bypass the result still sitting in ex
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;
    assign fwd1       = fwd_wen_i && (fwd_rd_i == rs1) && (rs1 != '0);
    assign fwd2       = fwd_wen_i && (fwd_rd_i == rs2) && (rs2 != '0);
    assign rs1_val    = fwd1 ? fwd_data_i : rs1_data_i;
    assign rs2_val    = fwd2 ? fwd_data_i : rs2_data_i;

    always_comb begin
        id_ex_o.valid   = accept;
        id_ex_o.pc      = pc_i;
        id_ex_o.alu_op  = alu_op;
        id_ex_o.src1    = rs1_val;
        id_ex_o.src2    = use_imm ? imm : rs2_val;
        id_ex_o.rd      = rd;
        id_ex_o.wen     = wen;
        id_ex_o.ebreak  = ebreak;
        id_ex_o.illegal = illegal;
    end

    assign halt_req_o = accept && ebreak;

    // control block must drop acceptance right after an ebreak
    assert property (@(posedge clk) disable iff (!rst_n) halt_req_o |=> !inst_ready_o);

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int SHAMT_W    = 6;                        // rv64 shift amount width

    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10                                // lui result
    } alu_op_e;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;              // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;          // sub and sra

endpackage

/* hw/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // control block register offsets
    localparam logic [APB_AW-1:0] CTRL_ADDR    = 8'h00;
    localparam logic [APB_AW-1:0] STATUS_ADDR  = 8'h04;
    localparam logic [APB_AW-1:0] RETIRED_ADDR = 8'h08;
    localparam logic [APB_AW-1:0] HALT_PC_ADDR = 8'h0C;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  ebreak;
        logic                  illegal;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;                       // register actually written
        logic [XLEN-1:0]       data;
        logic                  ebreak;
        logic                  illegal;
    } retire_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* hw/rv_regfile.sv */
module rv_regfile
    import rv_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    input  logic                  wen_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];   // x0 hardwired
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // x0 writes are dropped so the read values hold
    assert property (@(posedge clk) disable iff (!rst_n)
        (wen_i && (waddr_i == '0)) ##1 $stable(raddr1_i) |-> $stable(rdata1_o));
    assert property (@(posedge clk) disable iff (!rst_n)
        (wen_i && (waddr_i == '0)) ##1 $stable(raddr2_i) |-> $stable(rdata2_o));

endmodule

/* test/tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [XLEN-1:0] model_rf [NUM_REGS];                     // architectural registers

// f3 selects the operation and alt picks sub or sra
function automatic logic [XLEN-1:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] x,
                                              input logic [XLEN-1:0] y);
    case (f3)
        3'd0: return alt ? x - y : x + y;
        3'd1: return x << y[5:0];
        3'd2: return {{(XLEN-1){1'b0}}, $signed(x) < $signed(y)};
        3'd3: return {{(XLEN-1){1'b0}}, x < y};
        3'd4: return x ^ y;
        3'd5: begin
            if (alt) begin
                return $unsigned($signed(x) >>> y[5:0]);
            end
            return x >> y[5:0];
        end
        3'd6: return x | y;
        default: return x & y;
    endcase
endfunction

// executes one instruction in program order and returns the retire it must produce
function automatic retire_t model_step(input logic [INST_W-1:0] inst,
                                       input logic [XLEN-1:0] pc);
    retire_t         r;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] v1, v2;
    logic            legal, writes;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = pc;
    r.rd    = inst[11:7];
    v1      = model_rf[inst[19:15]];
    v2      = model_rf[inst[24:20]];
    imm     = {{(XLEN-12){inst[31]}}, inst[31:20]};
    res     = '0;
    legal   = 1'b1;
    writes  = 1'b1;
    case (inst[6:0])
        7'h33: begin
            legal = (inst[31:25] == 7'h00) ||
                    (inst[31:25] == 7'h20 && (inst[14:12] == 3'd0 || inst[14:12] == 3'd5));
            res   = model_alu(inst[14:12], inst[30], v1, v2);
        end
        7'h13: begin
            legal = !(inst[14:12] == 3'd1 && inst[31:26] != 6'd0) &&
                    !(inst[14:12] == 3'd5 && {inst[31], inst[29:26]} != 5'd0);
            res   = model_alu(inst[14:12], inst[14:12] == 3'd5 && inst[30], v1, imm);
        end
        7'h37: res = {{(XLEN-32){inst[31]}}, inst[31:12], 12'h000};
        7'h73: begin
            r.ebreak = (inst == 32'h0010_0073);
            legal    = r.ebreak;
            writes   = 1'b0;
        end
        default: legal = 1'b0;
    endcase
    r.illegal = !legal;
    if (legal && writes && r.rd != 5'd0) begin
        r.wen          = 1'b1;
        r.data         = res;
        model_rf[r.rd] = res;
    end
    return r;
endfunction

`endif

/* test/tb_core_slice.sv */
module tb_core_slice
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int NUM_INSTS   = 400;
    localparam int STALL_LIMIT = 20;
    localparam int DRAIN_LIMIT = 50;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              inst_valid_i;
    logic [INST_W-1:0] inst_i;
    logic [XLEN-1:0]   pc_i;
    logic              inst_ready_o;
    retire_t           retire_o;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    retire_t           exp_q [$];                         // retires still in flight
    logic [31:0]       lcg_state;
    logic [XLEN-1:0]   next_pc;
    logic [4:0]        last_rd;
    logic [31:0]       halt_pc_exp;
    logic              took_inst, model_halted, expect_stall, force_ebreak;
    int                errors, model_retires, sent_total;
    string             test_name;

    rv_core_slice dut_i (
        .clk, .rst_n, .inst_valid_i, .inst_i, .pc_i, .inst_ready_o, .retire_o,
        .apb_i (apb_req), .apb_o (apb_rsp)
    );

    `include "tb_rv_model.svh"

    initial forever #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned lcg_range(input int unsigned n);
        logic [31:0] v;
        v = lcg_next();
        return {8'd0, v[31:8]} % n;                       // low bits of an lcg are weak
    endfunction

    function automatic logic [4:0] pick_src();
        return (lcg_range(2) == 0) ? last_rd : 5'(lcg_range(32));  // dependency bias
    endfunction

    function automatic logic [INST_W-1:0] gen_inst();
        int unsigned       kind;
        logic [4:0]        rd, rs1, rs2;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic [11:0]       imm;
        logic [31:0]       bits;
        logic [INST_W-1:0] inst;
        kind = force_ebreak ? 0 : lcg_range(100);
        rd   = (lcg_range(8) == 0) ? 5'd0 : 5'(lcg_range(32));
        rs1  = pick_src();
        rs2  = pick_src();
        f3   = 3'(lcg_range(8));
        bits = lcg_next();
        if (kind < 1) begin
            inst = 32'h0010_0073;
        end else if (kind < 4) begin
            inst = {bits[31:7], 7'h03};                   // unsupported load opcode
        end else if (kind < 14) begin
            inst = {bits[31:12], rd, 7'h37};
        end else if (kind < 54) begin
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && bits[0]) ? 7'h20 : 7'h00;
            inst = {f7, rs2, rs1, f3, rd, 7'h33};
        end else begin
            imm = bits[11:0];
            if (f3 == 3'd1) begin
                imm = {6'd0, bits[5:0]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, bits[6], 4'd0, bits[5:0]};   // srli or srai
            end
            inst = {imm, rs1, f3, rd, 7'h13};
        end
        last_rd = inst[11:7];
        return inst;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic slverr);
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;                           // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        if (apb_rsp.pready !== 1'b1) begin
            report_mismatch("pready", 32'd1, {31'd0, apb_rsp.pready});
        end
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    // checks retires against the model and feeds it every accepted instruction
    always @(negedge clk) begin
        if (rst_n) begin
            if (expect_stall && inst_ready_o !== 1'b0) begin
                errors++;
                $display("inst_ready_o stayed high in the cycle after an ebreak (%s)", test_name);
            end
            expect_stall = 1'b0;
            if (retire_o.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("retire at pc %h with no instruction outstanding", retire_o.pc);
                end else begin
                    if (retire_o !== exp_q[0]) begin
                        errors++;
                        $display("ERROR %s retire: expected %h, actual %h",
                                 test_name, exp_q[0], retire_o);
                    end
                    void'(exp_q.pop_front());
                end
            end
            took_inst = inst_valid_i && inst_ready_o;     // accepted at the coming edge
            if (took_inst) begin
                exp_q.push_back(model_step(inst_i, pc_i));
                model_retires++;
                if (inst_i == 32'h0010_0073) begin
                    model_halted = 1'b1;
                    expect_stall = 1'b1;
                    halt_pc_exp  = pc_i[31:0];
                end
            end
        end
    end

    task automatic send_stream(input int count);
        int sent, stall;
        sent  = 0;
        stall = 0;
        while (sent < count && !model_halted && stall <= STALL_LIMIT) begin
            @(posedge clk);
            #2;
            if (inst_valid_i && took_inst) begin
                sent++;
                stall        = 0;
                inst_valid_i = 1'b0;
            end else if (inst_valid_i) begin
                stall++;
            end
            if (!inst_valid_i && sent < count && !model_halted && lcg_range(4) != 0) begin
                inst_i       = gen_inst();
                pc_i         = next_pc;
                next_pc      = next_pc + 64'd4;
                inst_valid_i = 1'b1;
            end
        end
        if (stall > STALL_LIMIT) begin
            errors++;
            $display("instruction at pc %h was never accepted", pc_i);
        end
        inst_valid_i = 1'b0;
        sent_total += sent;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("pipeline did not drain, %0d retires missing (%s)", exp_q.size(), test_name);
        end
    endtask

    task automatic check_retired();
        logic [31:0] rdata;
        logic        slverr;
        wait_drained();
        apb_access(1'b0, RETIRED_ADDR, 32'd0, rdata, slverr);
        if (rdata !== 32'(model_retires)) begin
            report_mismatch("retired count", 32'(model_retires), rdata);
        end
    endtask

    task automatic check_halt();
        logic [31:0] rdata;
        logic        slverr;
        check_retired();
        apb_access(1'b0, STATUS_ADDR, 32'd0, rdata, slverr);
        if (rdata !== 32'd1) report_mismatch("status halted", 32'd1, rdata);
        apb_access(1'b0, HALT_PC_ADDR, 32'd0, rdata, slverr);
        if (rdata !== halt_pc_exp) report_mismatch("halt pc", halt_pc_exp, rdata);
        apb_access(1'b1, STATUS_ADDR, 32'd1, rdata, slverr);   // w1c
        model_halted = 1'b0;
        @(negedge clk);
        if (inst_ready_o !== 1'b1) begin
            errors++;
            $display("inst_ready_o did not come back after halted was cleared");
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        int          rounds;
        rst_n         = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        apb_req       = '0;
        lcg_state     = 32'd99403;
        next_pc       = 64'h0000_0000_8000_0000;
        last_rd       = 5'd0;
        halt_pc_exp   = '0;
        took_inst     = 1'b0;
        model_halted  = 1'b0;
        expect_stall  = 1'b0;
        force_ebreak  = 1'b0;
        errors        = 0;
        model_retires = 0;
        sent_total    = 0;
        rounds        = 0;
        test_name     = "reset";
        for (int i = 0; i < NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (inst_ready_o !== 1'b0) begin
                errors++;
                $display("inst_ready_o high before CTRL.run was set");
            end
        end
        apb_access(1'b1, CTRL_ADDR, 32'd1, rdata, slverr);

        test_name = "alu stream";
        while (sent_total < NUM_INSTS && rounds < 50) begin
            send_stream(NUM_INSTS - sent_total);
            if (model_halted) check_halt();               // random ebreak hit
            rounds++;
        end
        if (sent_total < NUM_INSTS) begin
            errors++;
            $display("only %0d of %0d instructions were sent", sent_total, NUM_INSTS);
        end
        check_retired();

        test_name    = "ebreak";
        force_ebreak = 1'b1;
        send_stream(1);
        force_ebreak = 1'b0;
        check_halt();

        test_name = "apb errors";
        apb_access(1'b0, 8'h10, 32'd0, rdata, slverr);
        if (slverr !== 1'b1) report_mismatch("unmapped pslverr", 32'd1, {31'd0, slverr});
        apb_access(1'b1, RETIRED_ADDR, 32'hdead_beef, rdata, slverr);
        if (slverr !== 1'b1) report_mismatch("retired write pslverr", 32'd1, {31'd0, slverr});
        check_retired();                                  // count untouched by the write

        wait_drained();
        $display("%0d instructions retired, %0d errors", model_retires, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
